// ==== verilog/motion_config.svh ====
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// frame geometry of the on-chip store
`define FRAME_W 16 // pixels per line
`define FRAME_H 8  // lines per frame

// luma difference above which a pixel moved
`define DIFF_THR 60

// fewest moving pixels that make an object
`define MIN_DISC 6

// low byte sample to disp_valid
`define PIPE_LAT 3

`endif

// ==== verilog/motion_pkg.sv ====
`include "motion_config.svh"

package motion_pkg;

    // pixel coordinates
    typedef logic [$clog2(`FRAME_W)-1:0] x_t;
    typedef logic [$clog2(`FRAME_H)-1:0] y_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] pad; // always zero
        logic [7:0] y;
    } gray16_t;

    // colour in camera/fusion views, padded luma in gray/binary views
    typedef union packed {
        rgb565_t rgb;
        gray16_t gray;
    } disp_word_u;

    // pixel stream between stages
    typedef struct packed {
        logic    valid;
        x_t      x;
        y_t      y;
        rgb565_t pix;
    } pix_t;

    typedef struct packed {
        logic found;
        x_t   x_min;
        x_t   x_max;
        y_t   y_min;
        y_t   y_max;
    } box_t;

    typedef enum logic [1:0] {
        VIEW_CAMERA = 2'd0,
        VIEW_GRAY   = 2'd1,
        VIEW_BINARY = 2'd2,
        VIEW_FUSION = 2'd3
    } view_e;

endpackage

// ==== verilog/cam_capture.sv ====
module cam_capture (
    input  logic               cam_pclk,
    input  logic               arst_n,
    input  logic               cam_hs,
    input  logic               cam_vs,
    input  logic [7:0]         cam_data,
    output motion_pkg::pix_t   cap_pix,
    output logic               frame_end
);

    import motion_pkg::*;

    logic       hs_q;
    logic       vs_q;
    logic       phase;   // 0 = high byte expected
    logic [7:0] hi_byte;
    x_t         x_cnt;
    y_t         y_cnt;
    logic       hs_fall;
    logic       vs_rise;

    assign hs_fall = hs_q & ~cam_hs;
    assign vs_rise = cam_vs & ~vs_q;

    // first byte of a pair is held until its partner arrives
    always_ff @(posedge cam_pclk) begin
        if (cam_hs && !phase) begin
            hi_byte <= cam_data;
        end
    end

    always_ff @(posedge cam_pclk or negedge arst_n) begin
        if (!arst_n) begin
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            phase     <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            cap_pix   <= '0;
            frame_end <= 1'b0;
        end else begin
            hs_q          <= cam_hs;
            vs_q          <= cam_vs;
            frame_end     <= vs_rise;
            cap_pix.valid <= 1'b0; // strobe
            if (cam_hs) begin
                phase <= ~phase;
                if (phase) begin
                    cap_pix <= '{valid: 1'b1, x: x_cnt, y: y_cnt,
                                 pix: rgb565_t'({hi_byte, cam_data})};
                    x_cnt   <= x_cnt + 1'b1;
                end
            end else begin
                phase <= 1'b0; // resync on blanking
            end
            if (hs_fall) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end
            if (vs_rise) begin
                y_cnt <= '0;
            end
        end
    end

endmodule

// ==== verilog/motion_detect.sv ====
`include "motion_config.svh"

module motion_detect (
    input  logic               cam_pclk,
    input  logic               arst_n,
    input  motion_pkg::pix_t   cap_pix,
    input  logic               frame_end,
    output motion_pkg::pix_t   det_pix,
    output logic               motion,
    output logic [7:0]         luma,
    output logic               det_frame_end
);

    import motion_pkg::*;

    localparam int DEPTH  = `FRAME_W * `FRAME_H;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [7:0]        r8;
    logic [7:0]        g8;
    logic [7:0]        b8;
    logic [15:0]       luma_sum;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        store [DEPTH]; // previous frame luma
    logic [7:0]        luma_s1;
    logic [7:0]        prev_s1;
    logic [7:0]        diff;
    pix_t              pix_s1;
    logic              first_frame;
    logic [1:0]        fe_dly;

    // widen to 8 bits by replicating the msbs
    always_comb begin
        r8       = {cap_pix.pix.r, cap_pix.pix.r[4:2]};
        g8       = {cap_pix.pix.g, cap_pix.pix.g[5:4]};
        b8       = {cap_pix.pix.b, cap_pix.pix.b[4:2]};
        luma_sum = 16'd77 * 16'(r8) + 16'd150 * 16'(g8) + 16'd29 * 16'(b8);
        addr     = ADDR_W'(cap_pix.y) * ADDR_W'(`FRAME_W) + ADDR_W'(cap_pix.x);
    end

    // read old value and overwrite in the same cycle
    always_ff @(posedge cam_pclk) begin
        if (cap_pix.valid) begin
            prev_s1     <= store[addr];
            store[addr] <= luma_sum[15:8];
            luma_s1     <= luma_sum[15:8];
        end
    end

    assign diff = (luma_s1 > prev_s1) ? luma_s1 - prev_s1 : prev_s1 - luma_s1;

    always_ff @(posedge cam_pclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_s1      <= '0;
            det_pix     <= '0;
            motion      <= 1'b0;
            luma        <= '0;
            first_frame <= 1'b1;
            fe_dly      <= '0;
        end else begin
            pix_s1  <= cap_pix;
            det_pix <= pix_s1;
            luma    <= luma_s1;
            motion  <= pix_s1.valid && !first_frame && (diff > 8'(`DIFF_THR));
            fe_dly  <= {fe_dly[0], frame_end}; // keep in step with pixels
            if (frame_end) begin
                first_frame <= 1'b0; // store now holds a full frame
            end
        end
    end

    assign det_frame_end = fe_dly[1];

endmodule

// ==== verilog/box_tracker.sv ====
`include "motion_config.svh"

module box_tracker (
    input  logic               cam_pclk,
    input  logic               arst_n,
    input  motion_pkg::pix_t   det_pix,
    input  logic               motion,
    input  logic               det_frame_end,
    output motion_pkg::box_t   box
);

    import motion_pkg::*;

    localparam int CNT_W = $clog2(`FRAME_W * `FRAME_H + 1);

    logic [CNT_W-1:0] cnt; // moving pixels this frame
    x_t               x_lo;
    x_t               x_hi;
    y_t               y_lo;
    y_t               y_hi;
    logic             hit;
    logic             enough;

    assign hit    = det_pix.valid & motion;
    assign enough = cnt >= CNT_W'(`MIN_DISC);

    always_ff @(posedge cam_pclk or negedge arst_n) begin
        if (!arst_n) begin
            box  <= '0;
            cnt  <= '0;
            x_lo <= '1;
            x_hi <= '0;
            y_lo <= '1;
            y_hi <= '0;
        end else if (det_frame_end) begin
            if (enough) begin
                box <= '{found: 1'b1, x_min: x_lo, x_max: x_hi,
                         y_min: y_lo, y_max: y_hi};
            end else begin
                box <= '0;
            end
            // re-arm for the next frame
            cnt  <= '0;
            x_lo <= '1;
            x_hi <= '0;
            y_lo <= '1;
            y_hi <= '0;
        end else if (hit) begin
            cnt <= cnt + 1'b1;
            if (det_pix.x < x_lo) begin
                x_lo <= det_pix.x;
            end
            if (det_pix.x > x_hi) begin
                x_hi <= det_pix.x;
            end
            if (det_pix.y < y_lo) begin
                y_lo <= det_pix.y;
            end
            if (det_pix.y > y_hi) begin
                y_hi <= det_pix.y;
            end
        end
    end

endmodule

// ==== verilog/display_mux.sv ====
module display_mux (
    input  logic                   cam_pclk,
    input  logic                   arst_n,
    input  motion_pkg::pix_t       det_pix,
    input  logic                   motion,
    input  logic [7:0]             luma,
    input  logic                   det_frame_end,
    input  motion_pkg::box_t       box,
    input  motion_pkg::view_e      view,
    output logic                   disp_valid,
    output motion_pkg::disp_word_u disp_word,
    output motion_pkg::x_t         disp_x,
    output motion_pkg::y_t         disp_y
);

    import motion_pkg::*;

    localparam rgb565_t RED = '{r: 5'h1f, g: 6'h00, b: 5'h00};

    view_e view_q; // fixed for a whole frame
    logic  in_x;
    logic  in_y;
    logic  on_border;

    always_ff @(posedge cam_pclk or negedge arst_n) begin
        if (!arst_n) begin
            view_q <= VIEW_CAMERA;
        end else if (det_frame_end) begin
            view_q <= view;
        end
    end

    always_comb begin
        in_x      = (det_pix.x >= box.x_min) && (det_pix.x <= box.x_max);
        in_y      = (det_pix.y >= box.y_min) && (det_pix.y <= box.y_max);
        on_border = box.found &&
                    ((((det_pix.x == box.x_min) || (det_pix.x == box.x_max)) && in_y) ||
                     (((det_pix.y == box.y_min) || (det_pix.y == box.y_max)) && in_x));
    end

    always_comb begin
        case (view_q)
            VIEW_CAMERA: disp_word.rgb = det_pix.pix;
            VIEW_GRAY:   disp_word.gray = '{pad: 8'h00, y: luma};
            VIEW_BINARY: disp_word.gray = '{pad: 8'h00, y: motion ? 8'hff : 8'h00};
            default:     disp_word.rgb = on_border ? RED : det_pix.pix; // fusion
        endcase
    end

    assign disp_valid = det_pix.valid;
    assign disp_x     = det_pix.x;
    assign disp_y     = det_pix.y;

endmodule

// ==== verilog/motion_top.sv ====
module motion_top (
    input  logic                   cam_pclk,
    input  logic                   arst_n,
    input  logic                   cam_hs,
    input  logic                   cam_vs,
    input  logic [7:0]             cam_data,
    input  motion_pkg::view_e      view,
    output logic                   disp_valid,
    output motion_pkg::disp_word_u disp_word,
    output motion_pkg::x_t         disp_x,
    output motion_pkg::y_t         disp_y,
    output motion_pkg::box_t       box
);

    import motion_pkg::*;

    pix_t       cap_pix;
    pix_t       det_pix;
    logic       frame_end;
    logic       det_frame_end;
    logic       motion;
    logic [7:0] luma;

    cam_capture u_cam_capture (
        .cam_pclk  (cam_pclk),
        .arst_n    (arst_n),
        .cam_hs    (cam_hs),
        .cam_vs    (cam_vs),
        .cam_data  (cam_data),
        .cap_pix   (cap_pix),
        .frame_end (frame_end)
    );

    motion_detect u_motion_detect (
        .cam_pclk      (cam_pclk),
        .arst_n        (arst_n),
        .cap_pix       (cap_pix),
        .frame_end     (frame_end),
        .det_pix       (det_pix),
        .motion        (motion),
        .luma          (luma),
        .det_frame_end (det_frame_end)
    );

    box_tracker u_box_tracker (
        .cam_pclk      (cam_pclk),
        .arst_n        (arst_n),
        .det_pix       (det_pix),
        .motion        (motion),
        .det_frame_end (det_frame_end),
        .box           (box)
    );

    display_mux u_display_mux (
        .cam_pclk      (cam_pclk),
        .arst_n        (arst_n),
        .det_pix       (det_pix),
        .motion        (motion),
        .luma          (luma),
        .det_frame_end (det_frame_end),
        .box           (box),
        .view          (view),
        .disp_valid    (disp_valid),
        .disp_word     (disp_word),
        .disp_x        (disp_x),
        .disp_y        (disp_y)
    );

endmodule

// ==== test/motion_properties.sv ====
module motion_properties (
    input logic             cam_pclk,
    input logic             arst_n,
    input logic             disp_valid,
    input motion_pkg::x_t   disp_x,
    input motion_pkg::y_t   disp_y,
    input motion_pkg::box_t box
);

    idle_in_reset: assert property (@(posedge cam_pclk) !arst_n |-> !disp_valid)
        else $error("disp_valid high while arst_n is low");

    // pixels of one line come every second cycle, x steps by one and never wraps
    x_in_line: assert property (@(posedge cam_pclk) disable iff (!arst_n)
        disp_valid && $past(disp_valid, 2) && (disp_y == $past(disp_y, 2))
            |-> (int'(disp_x) == int'($past(disp_x, 2)) + 1))
        else $error("disp_x did not step by one along the line");

    // a found box never has its corners swapped
    box_ordered: assert property (@(posedge cam_pclk) disable iff (!arst_n)
        box.found |-> (box.x_min <= box.x_max) && (box.y_min <= box.y_max))
        else $error("box found with a minimum above its maximum");

endmodule

bind motion_top motion_properties u_props (
    .cam_pclk   (cam_pclk),
    .arst_n     (arst_n),
    .disp_valid (disp_valid),
    .disp_x     (disp_x),
    .disp_y     (disp_y),
    .box        (box)
);

// ==== test/motion_checker.sv ====
`include "motion_config.svh"

module motion_checker (
    input  logic                   cam_pclk,
    input  logic                   arst_n,
    input  logic                   cam_hs,
    input  logic                   cam_vs,
    input  logic [7:0]             cam_data,
    input  motion_pkg::view_e      view,
    input  logic                   disp_valid,
    input  motion_pkg::disp_word_u disp_word,
    input  motion_pkg::x_t         disp_x,
    input  motion_pkg::y_t         disp_y,
    input  motion_pkg::box_t       box,
    input  logic                   report_req,
    output logic                   reported,
    output int                     errors,
    output int                     pending
);

    import motion_pkg::*;

    typedef struct packed {
        x_t          x;
        y_t          y;
        logic [15:0] word;
        logic [2:0]  test; // index for test_name
    } exp_t;

    exp_t       exp_q[$];
    logic [7:0] mstore [`FRAME_W * `FRAME_H]; // model of the previous frame
    int         checks [6];
    int         fails [6];
    int         stray;
    int         mx;
    int         my;
    int         cnt;
    int         x_lo;
    int         x_hi;
    int         y_lo;
    int         y_hi;
    logic       phase;
    logic       hs_q;
    logic       vs_q;
    logic       first;
    logic       seen;
    logic [7:0] hi;
    view_e      cur_view;
    box_t       mbox;

    function automatic string test_name(input int t);
        case (t)
            0: return "camera_view";
            1: return "gray_view";
            2: return "binary_view";
            3: return "fusion_view";
            4: return "box_found";
            default: return "reset_idle";
        endcase
    endfunction

    // 8 bit channels by msb replication, then the weighted sum
    function automatic logic [7:0] luma_of(input logic [15:0] w);
        int r;
        int g;
        int b;
        r = {w[15:11], w[15:13]};
        g = {w[10:5], w[10:9]};
        b = {w[4:0], w[4:2]};
        return 8'((77 * r + 150 * g + 29 * b) >> 8);
    endfunction

    function automatic logic on_border(input int x, input int y, input box_t b);
        logic in_x;
        logic in_y;
        in_x = (x >= b.x_min) && (x <= b.x_max);
        in_y = (y >= b.y_min) && (y <= b.y_max);
        return b.found && (((x == b.x_min || x == b.x_max) && in_y) ||
                           ((y == b.y_min || y == b.y_max) && in_x));
    endfunction

    task automatic rearm();
        cnt  = 0;
        x_lo = `FRAME_W;
        x_hi = -1;
        y_lo = `FRAME_H;
        y_hi = -1;
    endtask

    task automatic take_pixel(input logic [15:0] w);
        logic [7:0] l;
        int         d;
        int         a;
        logic       mv;
        exp_t       e;
        l = luma_of(w);
        a = my * `FRAME_W + mx;
        d = int'(l) - int'(mstore[a]);
        if (d < 0) begin
            d = -d;
        end
        mv        = !first && (d > `DIFF_THR);
        mstore[a] = l;
        if (mv) begin
            cnt  = cnt + 1;
            x_lo = (mx < x_lo) ? mx : x_lo;
            x_hi = (mx > x_hi) ? mx : x_hi;
            y_lo = (my < y_lo) ? my : y_lo;
            y_hi = (my > y_hi) ? my : y_hi;
        end
        e.x = x_t'(mx);
        e.y = y_t'(my);
        case (cur_view)
            VIEW_CAMERA: e = '{x: e.x, y: e.y, word: w, test: 3'd0};
            VIEW_GRAY:   e = '{x: e.x, y: e.y, word: {8'h00, l}, test: 3'd1};
            VIEW_BINARY: e = '{x: e.x, y: e.y, word: mv ? 16'h00ff : 16'h0000, test: 3'd2};
            default:     e = '{x: e.x, y: e.y, word: on_border(mx, my, mbox) ? 16'hf800 : w,
                               test: 3'd3};
        endcase
        exp_q.push_back(e);
        mx = mx + 1;
    endtask

    task automatic close_frame();
        if (cnt >= `MIN_DISC) begin
            mbox = '{found: 1'b1, x_min: x_t'(x_lo), x_max: x_t'(x_hi),
                     y_min: y_t'(y_lo), y_max: y_t'(y_hi)};
        end else begin
            mbox = '0;
        end
        rearm();
        first    = 1'b0;
        cur_view = view; // held by the stimulus through the gap
    endtask

    task automatic check_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("disp_valid high at x=%0d y=%0d with no pixel sent", disp_x, disp_y);
            stray = stray + 1;
            return;
        end
        e    = exp_q.pop_front();
        seen = 1'b1;
        checks[e.test]++;
        if (disp_x !== e.x || disp_y !== e.y) begin
            $display("Mismatch %s: expected pixel (%0d,%0d), actual (%0d,%0d)",
                     test_name(e.test), e.x, e.y, disp_x, disp_y);
            fails[e.test]++;
        end else if (disp_word !== e.word) begin
            $display("Mismatch %s at (%0d,%0d): expected %h, actual %h",
                     test_name(e.test), e.x, e.y, e.word, disp_word);
            fails[e.test]++;
        end
        if (e.x == 0 && e.y == 0) begin // box of the frame before
            checks[4]++;
            if (box !== mbox) begin
                $display("Mismatch box_found: expected %h, actual %h", mbox, box);
                fails[4]++;
            end
        end
    endtask

    task automatic print_report();
        int t;
        int total;
        int bad;
        total = 0;
        bad   = stray;
        checks[4]++; // box of the last frame
        if (box !== mbox) begin
            $display("Mismatch box_found: expected %h, actual %h", mbox, box);
            fails[4]++;
        end
        for (t = 0; t < 6; t++) begin
            $display("%s: %0d checks, %0d errors", test_name(t), checks[t], fails[t]);
            total = total + checks[t];
            bad   = bad + fails[t];
        end
        if (exp_q.size() != 0) begin
            $display("%0d pixels were sent but never reached the display", exp_q.size());
            bad = bad + exp_q.size();
        end
        $display("all tests: %0d checks, %0d errors", total, bad);
        errors   = bad;
        reported = 1'b1;
    endtask

    initial begin
        reported = 1'b0;
        errors   = 0;
        pending  = 0;
        stray    = 0;
        seen     = 1'b0;
        checks   = '{default: 0};
        fails    = '{default: 0};
    end

    always @(posedge cam_pclk) begin
        if (!arst_n) begin
            phase    = 1'b0;
            hs_q     = 1'b0;
            vs_q     = 1'b0;
            mx       = 0;
            my       = 0;
            first    = 1'b1;
            cur_view = VIEW_CAMERA;
            mbox     = '0;
            rearm();
        end else begin
            if (cam_hs && phase) begin
                take_pixel({hi, cam_data});
            end else if (cam_hs) begin
                hi = cam_data;
            end
            phase = cam_hs && !phase;
            if (hs_q && !cam_hs) begin
                mx = 0;
                my = my + 1;
            end
            if (cam_vs && !vs_q) begin
                my = 0;
                close_frame();
            end
            hs_q = cam_hs;
            vs_q = cam_vs;
        end
    end

    // outputs settle after the rising edge
    always @(negedge cam_pclk) begin
        if (!arst_n || (!seen && exp_q.size() == 0)) begin
            checks[5]++;
            if (disp_valid || box.found) begin
                $display("Mismatch reset_idle: expected valid=0 found=0, actual valid=%b found=%b",
                         disp_valid, box.found);
                fails[5]++;
            end
        end
        if (arst_n && disp_valid) begin
            check_output();
        end
        pending = exp_q.size();
    end

    always @(posedge report_req) begin
        print_report();
    end

endmodule

// ==== test/motion_tb.sv ====
`include "motion_config.svh"

module motion_tb;

    import motion_pkg::*;

    localparam int     FRAMES    = 16;
    localparam int     MAX_BLANK = 6;
    localparam int     VS_GAP    = 13;
    localparam longint LIMIT     = longint'(FRAMES) *
        (`FRAME_H * (2 * `FRAME_W + MAX_BLANK) + VS_GAP) * 40 * 2 + 2000;

    logic        cam_pclk;
    logic        arst_n;
    logic        cam_hs;
    logic        cam_vs;
    logic [7:0]  cam_data;
    view_e       view;
    logic        disp_valid;
    disp_word_u  disp_word;
    x_t          disp_x;
    y_t          disp_y;
    box_t        box;
    logic        report_req;
    logic        reported;
    int          errors;
    int          pending;
    logic [31:0] lcg_state;
    logic [15:0] bg [`FRAME_W * `FRAME_H]; // still background
    int          sq_x;
    int          sq_y;
    int          sq_n;

    initial cam_pclk = 1'b0;
    always #20 cam_pclk = ~cam_pclk;

    motion_top DUT (.*);

    motion_checker chk (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge cam_pclk);
            cam_hs   = 1'b0;
            cam_data = 8'(lcg_next() >> 24); // bus noise in blanking
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge cam_pclk);
        cam_hs   = 1'b1;
        cam_data = b;
    endtask

    task automatic place_square();
        sq_n = 1 + int'(lcg_next() >> 30);
        sq_x = int'(lcg_next() >> 20) % (`FRAME_W - sq_n + 1);
        sq_y = int'(lcg_next() >> 20) % (`FRAME_H - sq_n + 1);
    endtask

    // white square over a dark background
    task automatic send_frame();
        int          x;
        int          y;
        logic [15:0] w;
        for (y = 0; y < `FRAME_H; y++) begin
            for (x = 0; x < `FRAME_W; x++) begin
                if (x >= sq_x && x < sq_x + sq_n && y >= sq_y && y < sq_y + sq_n) begin
                    w = 16'hffff;
                end else begin
                    w = bg[y * `FRAME_W + x];
                end
                send_byte(w[15:8]);
                send_byte(w[7:0]);
            end
            idle(1 + int'(lcg_next() >> 28) % MAX_BLANK);
        end
    endtask

    task automatic frame_gap(input view_e nv);
        idle(2);
        @(negedge cam_pclk);
        view   = nv; // stays until the next gap
        cam_vs = 1'b1;
        repeat (2) @(negedge cam_pclk);
        cam_vs = 1'b0;
        idle(8);
    endtask

    initial begin
        view_e       nv;
        logic [31:0] r;
        int          i;
        int          f;
        int          n;
        lcg_state  = 32'ha5a2fda8;
        arst_n     = 1'b0;
        cam_hs     = 1'b0;
        cam_vs     = 1'b0;
        cam_data   = 8'h00;
        view       = VIEW_CAMERA;
        report_req = 1'b0;
        for (i = 0; i < `FRAME_W * `FRAME_H; i++) begin
            r     = lcg_next();
            bg[i] = {2'b00, r[26:24], 2'b00, r[23:20], 2'b00, r[19:17]};
        end
        place_square();
        repeat (4) @(posedge cam_pclk);
        @(negedge cam_pclk);
        arst_n = 1'b1;
        idle(3);
        for (f = 0; f < FRAMES; f++) begin
            send_frame();
            if (f < 4) begin
                nv = view_e'(2'(f + 1)); // early frames walk through all views
            end else begin
                nv = view_e'(2'(lcg_next() >> 30));
            end
            frame_gap(nv);
            place_square();
        end
        for (n = 0; n < 8 * `PIPE_LAT && pending != 0; n++) begin
            @(negedge cam_pclk);
        end
        report_req = 1'b1;
        wait (reported);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired after %0d time units, the run did not complete", LIMIT);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/motion_pkg.sv
verilog/cam_capture.sv
verilog/motion_detect.sv
verilog/box_tracker.sv
verilog/display_mux.sv
verilog/motion_top.sv
test/motion_properties.sv
test/motion_checker.sv
test/motion_tb.sv

// ==== Makefile ====
SIM  = obj_dir/Vmotion_tb
SRCS = $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module motion_tb -f list.f

run: $(SIM)
	./$(SIM) > sim.log; cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
